// File: mm_mac_pipe.sv
`timescale 1ns/1ps

module mm_mac_pipe (
    input  logic              clk,
    input  logic              rst_n,
    input  mm_pkg::term_tag_t tag,
    input  mm_pkg::data_t     a_data,
    input  mm_pkg::data_t     b_data,
    output mm_pkg::mem_wr_t   res_wr
);
    import mm_pkg::*;

    term_tag_t tag_s0;
    term_tag_t tag_s1;
    term_tag_t tag_s2;

    data_t a_s1;
    data_t b_s1;
    acc_t  prod_s2;
    acc_t  acc;
    acc_t  acc_next;

    // ********************
    // Tag pipeline
    // ********************
    // Stage 0 lines the tag up with the RAM read data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_s0 <= '0;
            tag_s1 <= '0;
            tag_s2 <= '0;
        end else begin
            tag_s0 <= tag;
            tag_s1 <= tag_s0;
            tag_s2 <= tag_s1;
        end
    end

    // ********************
    // Datapath
    // ********************
    always_ff @(posedge clk) begin
        a_s1 <= a_data;
        b_s1 <= b_data;
    end

    always_ff @(posedge clk) begin
        prod_s2 <= acc_t'(a_s1) * acc_t'(b_s1);
    end

    // First term of a dot product reloads instead of adding
    always_comb begin
        if (tag_s2.first) begin
            acc_next = prod_s2;
        end else begin
            acc_next = acc + prod_s2;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_s2.valid) begin
            acc <= acc_next;
        end
    end

    // ********************
    // Result write
    // ********************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_wr <= '0;
        end else begin
            res_wr.we   <= tag_s2.valid && tag_s2.last;
            res_wr.addr <= tag_s2.out_addr;
            res_wr.data <= data_t'(acc_next[DATA_W-1:0]);
        end
    end

endmodule

// File: mm_pkg.sv
package mm_pkg;

    // ********************
    // Widths and sizes
    // ********************
    localparam int DATA_W    = 32;
    localparam int ACC_W     = 64;
    localparam int ADDR_W    = 10;
    localparam int MEM_DEPTH = 1024;
    localparam int DIM_W     = 10;

    // RAM read, operand register, multiply, accumulate
    localparam int PIPE_DEPTH = 4;

    // ********************
    // Types
    // ********************
    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic [DIM_W-1:0]         dim_t;

    typedef struct packed {
        dim_t m;
        dim_t n;
        dim_t k;
    } mm_dims_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t data;
    } mem_wr_t;

    // Travels down the pipeline alongside each operand pair
    typedef struct packed {
        logic  valid;
        logic  first;
        logic  last;
        addr_t out_addr;
    } term_tag_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_DRAIN
    } seq_state_t;

endpackage

// File: mm_ram.sv
`timescale 1ns/1ps

module mm_ram (
    input  logic            clk,
    input  mm_pkg::mem_wr_t wr,
    input  mm_pkg::addr_t   rd_addr,
    output mm_pkg::data_t   rd_data
);
    import mm_pkg::*;

    data_t mem [MEM_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Registered read returns the old word when the same address is written in that cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: mm_sequencer.sv
`timescale 1ns/1ps

module mm_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  mm_pkg::mm_dims_t  dims,
    output mm_pkg::addr_t     a_rd_addr,
    output mm_pkg::addr_t     b_rd_addr,
    output mm_pkg::term_tag_t tag,
    output logic              busy,
    output logic              done
);
    import mm_pkg::*;

    seq_state_t state;
    mm_dims_t   dims_q;

    // Loop indices
    dim_t i;
    dim_t j;
    dim_t p;

    // Running pointers into A, B and C
    addr_t a_row_base;
    addr_t b_ptr;
    addr_t res_addr;

    logic [1:0] drain_cnt;

    logic p_last;
    logic j_last;
    logic i_last;
    logic last_term;

    // ********************
    // Loop end detection
    // ********************
    always_comb begin
        p_last    = (p == dims_q.k - dim_t'(1));
        j_last    = (j == dims_q.n - dim_t'(1));
        i_last    = (i == dims_q.m - dim_t'(1));
        last_term = (state == SEQ_RUN) && p_last && j_last && i_last;
    end

    // ********************
    // Control FSM
    // ********************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            done      <= 1'b0;
            drain_cnt <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        state <= SEQ_RUN;
                    end
                end
                SEQ_RUN: begin
                    if (last_term) begin
                        state     <= SEQ_DRAIN;
                        drain_cnt <= 2'(PIPE_DEPTH - 1);
                    end
                end
                SEQ_DRAIN: begin
                    // The last write lands in the final drain cycle
                    if (drain_cnt == '0) begin
                        state <= SEQ_IDLE;
                        done  <= 1'b1;
                    end else begin
                        drain_cnt <= drain_cnt - 2'd1;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Dimensions are only taken in idle, so a start during a run leaves them alone
    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && start) begin
            dims_q <= dims;
        end
    end

    // ********************
    // Loop counters and pointers
    // ********************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            i          <= '0;
            j          <= '0;
            p          <= '0;
            a_row_base <= '0;
            b_ptr      <= '0;
            res_addr   <= '0;
        end else if (state == SEQ_IDLE) begin
            if (start) begin
                i          <= '0;
                j          <= '0;
                p          <= '0;
                a_row_base <= '0;
                b_ptr      <= '0;
                res_addr   <= '0;
            end
        end else if (state == SEQ_RUN) begin
            if (p_last) begin
                p        <= '0;
                res_addr <= res_addr + addr_t'(1);
                if (j_last) begin
                    // Next row of A, back to column 0 of B
                    j          <= '0;
                    i          <= i + dim_t'(1);
                    a_row_base <= a_row_base + addr_t'(dims_q.k);
                    b_ptr      <= '0;
                end else begin
                    j     <= j + dim_t'(1);
                    b_ptr <= addr_t'(j) + addr_t'(1);
                end
            end else begin
                p     <= p + dim_t'(1);
                b_ptr <= b_ptr + addr_t'(dims_q.n);
            end
        end
    end

    // ********************
    // Issue
    // ********************
    always_comb begin
        a_rd_addr    = a_row_base + addr_t'(p);
        b_rd_addr    = b_ptr;
        tag.valid    = (state == SEQ_RUN);
        tag.first    = (p == '0);
        tag.last     = p_last;
        tag.out_addr = res_addr;
    end

    assign busy = (state != SEQ_IDLE);

endmodule

// File: mm_top.sv
`timescale 1ns/1ps

module mm_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  mm_pkg::mm_dims_t dims,
    input  mm_pkg::mem_wr_t  load_a,
    input  mm_pkg::mem_wr_t  load_b,
    input  mm_pkg::addr_t    res_rd_addr,
    output mm_pkg::data_t    res_rd_data,
    output logic             busy,
    output logic             done
);
    import mm_pkg::*;

    addr_t     a_rd_addr;
    addr_t     b_rd_addr;
    term_tag_t tag;
    data_t     a_data;
    data_t     b_data;
    mem_wr_t   res_wr;

    // ********************
    // Control and datapath
    // ********************
    mm_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .dims      (dims),
        .a_rd_addr (a_rd_addr),
        .b_rd_addr (b_rd_addr),
        .tag       (tag),
        .busy      (busy),
        .done      (done)
    );

    mm_mac_pipe u_mac (
        .clk    (clk),
        .rst_n  (rst_n),
        .tag    (tag),
        .a_data (a_data),
        .b_data (b_data),
        .res_wr (res_wr)
    );

    // ********************
    // Matrix memories
    // ********************
    // A and B are written only from outside, C only by the MAC pipeline
    mm_ram ram_a (
        .clk     (clk),
        .wr      (load_a),
        .rd_addr (a_rd_addr),
        .rd_data (a_data)
    );

    mm_ram ram_b (
        .clk     (clk),
        .wr      (load_b),
        .rd_addr (b_rd_addr),
        .rd_data (b_data)
    );

    mm_ram ram_c (
        .clk     (clk),
        .wr      (res_wr),
        .rd_addr (res_rd_addr),
        .rd_data (res_rd_data)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build the matrix multiplier testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mm -f vlog.f -o tb_mm_sim \
    > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_mm_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "Simulator returned an error status"
grep -q "^TEST PASSED$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: tb_mm.sv
`timescale 1ns/1ps

module tb_mm;
    import mm_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     start;
    mm_dims_t dims;
    mem_wr_t  load_a;
    mem_wr_t  load_b;
    addr_t    res_rd_addr;
    data_t    res_rd_data;
    logic     busy;
    logic     done;

    // Host copies of A and B for the reference model
    data_t a_mat [MEM_DEPTH];
    data_t b_mat [MEM_DEPTH];
    int    m_dim;
    int    n_dim;
    int    k_dim;
    int    check_errors = 0;
    int    cycle_count = 0;
    int    hand_c [4];

    mm_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .dims        (dims),
        .load_a      (load_a),
        .load_b      (load_b),
        .res_rd_addr (res_rd_addr),
        .res_rd_data (res_rd_data),
        .busy        (busy),
        .done        (done)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests never finished", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ********************
    // Stimulus helpers
    // ********************
    // Full-range values make the sums wrap past 32 bits
    function automatic data_t random_elem(input bit big);
        if (big) begin
            return data_t'($urandom);
        end else begin
            return data_t'(int'($urandom_range(200)) - 100);
        end
    endfunction

    task automatic fill_random(input bit do_a, input bit do_b, input bit big);
        for (int idx = 0; idx < m_dim * k_dim; idx++) begin
            if (do_a) a_mat[idx] = random_elem(big);
        end
        for (int idx = 0; idx < k_dim * n_dim; idx++) begin
            if (do_b) b_mat[idx] = random_elem(big);
        end
    endtask

    task automatic load_matrices(input bit do_a, input bit do_b);
        int a_cnt;
        int b_cnt;
        a_cnt = do_a ? m_dim * k_dim : 0;
        b_cnt = do_b ? k_dim * n_dim : 0;
        for (int idx = 0; idx < a_cnt || idx < b_cnt; idx++) begin
            @(posedge clk);
            #1;
            load_a.we   = (idx < a_cnt);
            load_a.addr = addr_t'(idx);
            load_a.data = a_mat[idx];
            load_b.we   = (idx < b_cnt);
            load_b.addr = addr_t'(idx);
            load_b.data = b_mat[idx];
        end
        @(posedge clk);
        #1;
        load_a.we = 1'b0;
        load_b.we = 1'b0;
    endtask

    task automatic run_mult(input bit poke_start);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        dims  = '{m: dim_t'(m_dim), n: dim_t'(n_dim), k: dim_t'(k_dim)};
        start = 1'b1;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            start = 1'b0;
            if (poke_start && cycles == 3) begin
                dims  = '{m: dim_t'(1), n: dim_t'(1), k: dim_t'(1)};
                start = 1'b1;
            end
        end while (!done);
        assert (cycles == m_dim * n_dim * k_dim + 5) else begin
            $display("Done came %0d cycles after start instead of %0d",
                     cycles, m_dim * n_dim * k_dim + 5);
            check_errors++;
        end
    endtask

    // ********************
    // Checks
    // ********************
    task automatic compare_word(input int idx, input data_t expected);
        res_rd_addr = addr_t'(idx);
        @(posedge clk);
        #1;
        assert (res_rd_data == expected) else begin
            $display("[ERROR] %0t res_rd_data C[%0d] expected %0d actual %0d",
                     $time, idx, expected, res_rd_data);
            check_errors++;
        end
    endtask

    task automatic check_result();
        longint acc;
        for (int i = 0; i < m_dim; i++) begin
            for (int j = 0; j < n_dim; j++) begin
                acc = 0;
                for (int p = 0; p < k_dim; p++) begin
                    acc += longint'(a_mat[i * k_dim + p]) * longint'(b_mat[p * n_dim + j]);
                end
                compare_word(i * n_dim + j, data_t'(acc[DATA_W-1:0]));
            end
        end
    endtask

    task automatic check_low(input string name, input logic value);
        assert (value == 1'b0) else begin
            $display("[ERROR] %0t %s expected 0 actual %b", $time, name, value);
            check_errors++;
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic run_case(input int m, input int n, input int k, input bit big,
                            input bit poke_start);
        m_dim = m;
        n_dim = n;
        k_dim = k;
        fill_random(1'b1, 1'b1, big);
        load_matrices(1'b1, 1'b1);
        run_mult(poke_start);
        check_result();
    endtask

    // Reset lands well inside a 27-term run and holds past the cycle done would have pulsed
    task automatic abort_run();
        m_dim = 3;
        n_dim = 3;
        k_dim = 3;
        @(posedge clk);
        #1;
        dims  = '{m: dim_t'(m_dim), n: dim_t'(n_dim), k: dim_t'(k_dim)};
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        repeat (6) @(posedge clk);
        #1;
        rst_n = 1'b0;
        repeat (m_dim * n_dim * k_dim) begin
            @(posedge clk);
            #1;
            check_low("busy", busy);
            check_low("done", done);
        end
        rst_n = 1'b1;
    endtask

    // ********************
    // Test sequence
    // ********************
    initial begin
        void'($urandom(32'h5814));
        rst_n       = 1'b0;
        start       = 1'b0;
        dims        = '0;
        load_a      = '0;
        load_b      = '0;
        res_rd_addr = '0;
        apply_reset();

        // Fixed 2x3 by 3x2 product against hand-computed values
        m_dim = 2;
        n_dim = 2;
        k_dim = 3;
        hand_c = '{58, 64, 139, 154};
        for (int idx = 0; idx < 6; idx++) begin
            a_mat[idx] = data_t'(idx + 1);
            b_mat[idx] = data_t'(idx + 7);
        end
        load_matrices(1'b1, 1'b1);
        run_mult(1'b0);
        for (int idx = 0; idx < 4; idx++) begin
            compare_word(idx, data_t'(hand_c[idx]));
        end

        run_case(4, 3, 5, 1'b1, 1'b0);

        // Outer product, row times column, single element
        run_case(3, 4, 1, 1'b0, 1'b0);
        run_case(1, 1, 6, 1'b0, 1'b0);
        run_case(1, 1, 1, 1'b1, 1'b0);

        // Stray start mid-run, then new shape over the same A words and a new B
        run_case(3, 4, 2, 1'b1, 1'b1);
        m_dim = 2;
        n_dim = 2;
        k_dim = 3;
        fill_random(1'b0, 1'b1, 1'b1);
        load_matrices(1'b0, 1'b1);
        run_mult(1'b0);
        check_result();

        abort_run();
        run_case(3, 3, 3, 1'b1, 1'b0);

        repeat (3) @(posedge clk);
        $display("Errors: %0d checks, %0d assertions", check_errors, UUT.u_props.fail_cnt);
        if (check_errors == 0 && UUT.u_props.fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb_mm_props.sv
`timescale 1ns/1ps

module tb_mm_props (
    input logic             clk,
    input logic             rst_n,
    input logic             start,
    input mm_pkg::mm_dims_t dims,
    input mm_pkg::mm_dims_t dims_q,
    input logic             busy,
    input logic             done,
    input mm_pkg::mem_wr_t  res_wr
);
    import mm_pkg::*;

    addr_t exp_addr;
    int    wr_cnt;
    int    run_mn;

    int done_fails  = 0;
    int we_fails    = 0;
    int dims_fails  = 0;
    int addr_fails  = 0;
    int count_fails = 0;
    int fail_cnt;

    assign fail_cnt = done_fails + we_fails + dims_fails + addr_fails + count_fails;

    // Expected write address and write count for the current run
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exp_addr <= '0;
            wr_cnt   <= 0;
        end else if (start && !busy) begin
            exp_addr <= '0;
            wr_cnt   <= 0;
            run_mn   <= int'(dims.m) * int'(dims.n);
        end else if (res_wr.we) begin
            exp_addr <= exp_addr + addr_t'(1);
            wr_cnt   <= wr_cnt + 1;
        end
    end

    // ********************
    // Properties
    // ********************
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            done_fails = done_fails + 1;
            $error("done stayed high for more than one cycle");
        end

    we_in_run: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> !res_wr.we)
        else begin
            we_fails = we_fails + 1;
            $error("Result write while the multiplier was idle");
        end

    dims_held: assert property (@(posedge clk) disable iff (!rst_n)
        start && busy |=> $stable(dims_q))
        else begin
            dims_fails = dims_fails + 1;
            $error("A start during a run changed the latched dimensions");
        end

    addr_order: assert property (@(posedge clk) disable iff (!rst_n)
        res_wr.we |-> res_wr.addr == exp_addr)
        else begin
            addr_fails = addr_fails + 1;
            $error("Result write address %0d out of order, expected %0d",
                   res_wr.addr, exp_addr);
        end

    write_count: assert property (@(posedge clk) disable iff (!rst_n) done |-> wr_cnt == run_mn)
        else begin
            count_fails = count_fails + 1;
            $error("Run finished after %0d result writes, expected %0d", wr_cnt, run_mn);
        end

endmodule

bind mm_top tb_mm_props u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .dims   (dims),
    .dims_q (u_seq.dims_q),
    .busy   (busy),
    .done   (done),
    .res_wr (res_wr)
);

// File: vlog.f
mm_pkg.sv
mm_ram.sv
mm_sequencer.sv
mm_mac_pipe.sv
mm_top.sv
tb_mm_props.sv
tb_mm.sv
